//--- list.f
logic/baser_pkg.sv
logic/baser_word_fifo.sv
logic/baser_transcoder_257b.sv
logic/baser_257b_checker.sv
logic/baser_257b_top.sv
verification/baser_257b_monitor.sv
verification/tb_baser_257b.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_baser_257b -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_baser_257b > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -x -F ">>> PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- verification/baser_257b_vectors.txt
# T name | Q count block0..block3, each 66-bit hex with the sync in the top bits
# W addr data pslverr | R addr rdata pslverr | P addr rdata polled for | B o_blk_ready
T reset_state
R 00 00000001 0
R 04 00000000 0
R 08 00000000 0
R 0C 00000000 0
R 10 00000000 0
T all_data
Q 2 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA
P 04 00000002
R 08 00000002 0
R 10 00000000 0
T control
Q 1 25555555555555555 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA
Q 1 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA 25555555555555555 1AAAAAAAAAAAAAAAA
Q 1 1AAAAAAAAAAAAAAAA 25555555555555555 25555555555555555 25555555555555555
Q 1 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA 25555555555555555
Q 1 25555555555555555 25555555555555555 25555555555555555 25555555555555555
P 04 00000007
R 0C 00000005 0
R 10 00000000 0
T invalid
Q 1 1AAAAAAAA00AAAAAA 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA
Q 1 3AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA
Q 1 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA 0AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA
Q 1 1AAAAAAAA00AAAAAA 1AAAAAAAAAAAAAAAA 25555555555555555 25555555555555500
Q 1 1AAAAAAAAAAAAAAAA 2555555555555555F 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA
P 04 0000000C
R 08 00000003 0
R 0C 00000009 0
R 10 00000004 0
T back_pressure
W 00 00000000 0
Q 5 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA 1AAAAAAAAAAAAAAAA
B 0
R 04 0000000C 0
W 00 00000001 0
P 04 00000011
R 08 00000008 0
R 10 00000004 0
T clear
W 00 00000003 0
R 04 00000000 0
R 08 00000000 0
R 0C 00000000 0
R 10 00000000 0
R 00 00000001 0
T bus_errors
R 14 00000000 1
W 08 00000005 1
R 08 00000000 0
R 1C 00000000 1

//--- verification/tb_baser_257b.sv
`timescale 1ns/1ps
`default_nettype none

module tb_baser_257b import baser_pkg::*; ();

    localparam int FIFO_DEPTH = 4;
    localparam int WAIT_LIMIT = 100;   // Cycles per wait
    localparam int POLL_LIMIT = 50;    // Reads per poll

    logic        clk;
    logic        rst;
    logic        blk_valid;
    baser_quad_t blk;
    logic        blk_ready;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    logic        chk_apb;
    logic [31:0] exp_data;
    logic        exp_err;
    logic        chk_ready;
    logic        exp_ready;
    int          mon_errors;
    int          mon_checks;

    int          tb_errors = 0;        // Timeouts and bad vector lines
    int          tests = 0;
    int          failed_tests = 0;
    int          test_start_err = 0;
    string       test_name = "";

    baser_257b_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk         (clk),
        .i_rst       (rst),
        .i_blk_valid (blk_valid),
        .i_blk       (blk),
        .o_blk_ready (blk_ready),
        .i_apb       (apb_req),
        .o_apb       (apb_rsp)
    );

    baser_257b_monitor u_monitor (
        .clk         (clk),
        .i_apb_req   (apb_req),
        .i_apb_rsp   (apb_rsp),
        .i_blk_ready (blk_ready),
        .i_chk_apb   (chk_apb),
        .i_exp_data  (exp_data),
        .i_exp_err   (exp_err),
        .i_chk_ready (chk_ready),
        .i_exp_ready (exp_ready),
        .o_errors    (mon_errors),
        .o_checks    (mon_checks)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // One APB transfer, setup then access phase
    task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                            input logic chk, input logic [31:0] edata, input logic eerr,
                            output logic [31:0] rdata);
        int n;
        n = 0;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        chk_apb         = chk;
        exp_data        = edata;
        exp_err         = eerr;
        @(posedge clk);
        while (!apb_rsp.pready && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!apb_rsp.pready) begin
            $display("Timeout: APB slave never raised pready at address 0x%02h", addr);
            tb_errors++;
        end
        rdata = apb_rsp.prdata;
        @(negedge clk);
        apb_req = '0;
        chk_apb = 1'b0;
    endtask

    task automatic send_quad(input baser_quad_t q);
        int n;
        int gap;
        n = 0;
        @(negedge clk);
        blk       = q;
        blk_valid = 1'b1;
        @(posedge clk);
        while (!blk_ready && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!blk_ready) begin
            $display("Timeout: o_blk_ready stayed low and the quad was not accepted");
            tb_errors++;
        end
        @(negedge clk);
        blk_valid = 1'b0;
        gap = int'($urandom_range(2, 0));   // Idle cycles between quads
        repeat (gap) @(negedge clk);
    endtask

    // Counter value marks the end of a drain
    task automatic poll_reg(input logic [4:0] addr, input logic [31:0] expected);
        logic [31:0] rdata;
        int          n;
        n     = 0;
        rdata = ~expected;
        while (rdata != expected && n < POLL_LIMIT) begin
            apb_xfer(1'b0, addr, 32'd0, 1'b0, 32'd0, 1'b0, rdata);
            n++;
        end
        if (rdata != expected) begin
            $display("Timeout: register 0x%02h never reached 0x%08h, last read 0x%08h",
                     addr, expected, rdata);
            tb_errors++;
        end
    endtask

    task automatic check_ready(input logic expected);
        @(negedge clk);
        chk_ready = 1'b1;
        exp_ready = expected;
        @(negedge clk);
        chk_ready = 1'b0;
    endtask

    task automatic finish_test();
        int errs;
        errs = tb_errors + mon_errors - test_start_err;
        if (test_name != "") begin
            tests++;
            if (errs == 0) begin
                $display("Test %s: passed", test_name);
            end else begin
                $display("Test %s: failed with %0d errors", test_name, errs);
                failed_tests++;
            end
        end
        test_start_err = tb_errors + mon_errors;
    endtask

    initial begin
        int          fd;
        int          code;
        int          reps;
        string       line;
        string       kind;
        string       name;
        logic [65:0] b0;
        logic [65:0] b1;
        logic [65:0] b2;
        logic [65:0] b3;
        logic [31:0] a_val;
        logic [31:0] d_val;
        logic [31:0] e_val;
        logic [31:0] rdata;
        baser_quad_t q;

        void'($urandom(32'h4fa7a641));
        rst       = 1'b1;
        blk_valid = 1'b0;
        blk       = '0;
        apb_req   = '0;
        chk_apb   = 1'b0;
        exp_data  = '0;
        exp_err   = 1'b0;
        chk_ready = 1'b0;
        exp_ready = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("verification/baser_257b_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/baser_257b_vectors.txt");
            tb_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                code = $sscanf(line, "%s", kind);
                if (code < 1 || kind == "#") continue;
                if (kind == "T") begin
                    finish_test();
                    code      = $sscanf(line, "%s %s", kind, name);
                    test_name = name;
                end else if (kind == "Q") begin
                    code = $sscanf(line, "%s %d %h %h %h %h", kind, reps, b0, b1, b2, b3);
                    q[0] = b0;   // Block 0 arrives first
                    q[1] = b1;
                    q[2] = b2;
                    q[3] = b3;
                    repeat (reps) send_quad(q);
                end else if (kind == "W") begin
                    code = $sscanf(line, "%s %h %h %h", kind, a_val, d_val, e_val);
                    apb_xfer(1'b1, a_val[4:0], d_val, 1'b1, 32'd0, e_val[0], rdata);
                end else if (kind == "R") begin
                    code = $sscanf(line, "%s %h %h %h", kind, a_val, d_val, e_val);
                    apb_xfer(1'b0, a_val[4:0], 32'd0, 1'b1, d_val, e_val[0], rdata);
                end else if (kind == "P") begin
                    code = $sscanf(line, "%s %h %h", kind, a_val, d_val);
                    poll_reg(a_val[4:0], d_val);
                end else if (kind == "B") begin
                    code = $sscanf(line, "%s %h", kind, a_val);
                    check_ready(a_val[0]);
                end else begin
                    $display("Unknown line in the vectors file: %s", line);
                    tb_errors++;
                end
            end
            $fclose(fd);
        end
        finish_test();

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, mon_checks, tb_errors + mon_errors);
        if (tb_errors + mon_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/baser_257b_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module baser_257b_monitor import baser_pkg::*; (
    input  logic        clk,
    input  apb_req_t    i_apb_req,
    input  apb_rsp_t    i_apb_rsp,
    input  logic        i_blk_ready,
    input  logic        i_chk_apb,    // Compare the current APB transfer
    input  logic [31:0] i_exp_data,   // Ignored on writes
    input  logic        i_exp_err,
    input  logic        i_chk_ready,
    input  logic        i_exp_ready,
    output int          o_errors,
    output int          o_checks
);

    int   errors = 0;
    int   checks = 0;
    logic done;

    // Transfer completes on the edge of the access phase with pready
    assign done     = i_apb_req.psel && i_apb_req.penable && i_apb_rsp.pready;
    assign o_errors = errors;
    assign o_checks = checks;

    always @(posedge clk) begin
        if (i_chk_apb && done) begin
            checks++;
            if (!i_apb_req.pwrite && i_apb_rsp.prdata !== i_exp_data) begin
                $display("[FAIL] t=%0d ns: read of 0x%02h returned 0x%08h, expected 0x%08h",
                         $time, i_apb_req.paddr, i_apb_rsp.prdata, i_exp_data);
                errors++;
            end
            if (i_apb_rsp.pslverr !== i_exp_err) begin
                $display("[FAIL] t=%0d ns: pslverr %0b at 0x%02h (pwrite %0b), expected %0b",
                         $time, i_apb_rsp.pslverr, i_apb_req.paddr, i_apb_req.pwrite,
                         i_exp_err);
                errors++;
            end
        end
        if (i_chk_ready) begin
            checks++;
            if (i_blk_ready !== i_exp_ready) begin
                $display("[FAIL] t=%0d ns: o_blk_ready is %0b, expected %0b",
                         $time, i_blk_ready, i_exp_ready);
                errors++;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/baser_257b_top.sv
`timescale 1ns/1ps
`default_nettype none

module baser_257b_top import baser_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_blk_valid,
    input  baser_quad_t i_blk,
    output logic        o_blk_ready,
    input  apb_req_t    i_apb,
    output apb_rsp_t    o_apb
);

    logic     tc_valid;
    tc_word_t tc_word;
    logic     fifo_ready;   // Not full
    logic     fifo_full;
    logic     fifo_empty;
    logic     fifo_valid;
    tc_word_t fifo_word;
    logic     chk_pop;

    assign fifo_ready = !fifo_full;
    assign fifo_valid = !fifo_empty;

    baser_transcoder_257b u_transcoder (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_valid (i_blk_valid),
        .i_quad  (i_blk),
        .o_ready (o_blk_ready),
        .o_valid (tc_valid),
        .o_word  (tc_word),
        .i_ready (fifo_ready)
    );

    baser_word_fifo #(
        .T_PAYLOAD (tc_word_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_push  (tc_valid && fifo_ready),
        .i_data  (tc_word),
        .i_pop   (chk_pop),
        .o_full  (fifo_full),
        .o_empty (fifo_empty),
        .o_data  (fifo_word)
    );

    baser_257b_checker u_checker (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_word       (fifo_word),
        .i_word_valid (fifo_valid),
        .o_pop        (chk_pop),
        .i_apb        (i_apb),
        .o_apb        (o_apb)
    );

endmodule

`default_nettype wire

//--- logic/baser_257b_checker.sv
`timescale 1ns/1ps
`default_nettype none

module baser_257b_checker import baser_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  tc_word_t i_word,
    input  logic     i_word_valid,
    output logic     o_pop,
    input  apb_req_t i_apb,
    output apb_rsp_t o_apb
);

    localparam logic [BLK_PAYLOAD_W-1:0] DATA_REF = {8{DATA_PATTERN}};
    localparam logic [BLK_PAYLOAD_W-1:0] CTRL_REF = {8{CTRL_PATTERN}};

    logic [TC_W-1:0] w;
    logic            seen_ctrl;
    logic            bad_word;   // Word counts as invalid once at most
    logic            enable;
    logic [31:0]     blk_cnt;
    logic [31:0]     data_cnt;
    logic [31:0]     ctrl_cnt;
    logic [31:0]     inv_cnt;
    logic            apb_access;
    logic            ctrl_wr;

    assign w     = i_word.word;
    assign o_pop = enable && i_word_valid;

    always_comb begin
        seen_ctrl = 1'b0;
        bad_word  = i_word.bad_sync;
        if (w[0]) begin
            for (int i = 0; i < 4; i++) begin
                if (w[1 + BLK_PAYLOAD_W*i +: BLK_PAYLOAD_W] != DATA_REF) bad_word = 1'b1;
            end
        end else begin
            // Offset is 5 + 64*i before the first control block, 1 + 64*i after it
            for (int i = 0; i < 3; i++) begin
                if (seen_ctrl) begin
                    if (w[1 + BLK_PAYLOAD_W*i +: BLK_PAYLOAD_W] !=
                        (w[1 + i] ? DATA_REF : CTRL_REF)) bad_word = 1'b1;
                end else if (w[1 + i]) begin
                    if (w[5 + BLK_PAYLOAD_W*i +: BLK_PAYLOAD_W] != DATA_REF) bad_word = 1'b1;
                end else begin
                    seen_ctrl = 1'b1;
                    if (w[5 + BLK_PAYLOAD_W*i +: CTRL_KEEP_W] !=
                        CTRL_REF[BLK_PAYLOAD_W-1:TYPE_W]) bad_word = 1'b1;
                end
            end
            if (seen_ctrl) begin
                if (w[1 + BLK_PAYLOAD_W*3 +: BLK_PAYLOAD_W] !=
                    (w[4] ? DATA_REF : CTRL_REF)) bad_word = 1'b1;
            end else if (w[4]) begin
                bad_word = 1'b1;   // Control word with no control block
            end else if (w[5 + BLK_PAYLOAD_W*3 +: CTRL_KEEP_W] !=
                         CTRL_REF[BLK_PAYLOAD_W-1:TYPE_W]) begin
                bad_word = 1'b1;
            end
        end
    end

    assign apb_access = i_apb.psel && i_apb.penable;
    assign ctrl_wr    = apb_access && i_apb.pwrite && (i_apb.paddr == REG_CTRL);

    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            enable   <= 1'b1;
            blk_cnt  <= '0;
            data_cnt <= '0;
            ctrl_cnt <= '0;
            inv_cnt  <= '0;
        end else begin
            if (ctrl_wr) enable <= i_apb.pwdata[0];
            if (ctrl_wr && i_apb.pwdata[1]) begin   // Clear wins over a pop
                blk_cnt  <= '0;
                data_cnt <= '0;
                ctrl_cnt <= '0;
                inv_cnt  <= '0;
            end else if (o_pop) begin
                blk_cnt <= blk_cnt + 32'd1;
                if (w[0]) data_cnt <= data_cnt + 32'd1;
                else      ctrl_cnt <= ctrl_cnt + 32'd1;
                if (bad_word) inv_cnt <= inv_cnt + 32'd1;
            end
        end
    end

    // Register read mux, no wait states
    always_comb begin
        o_apb.prdata  = '0;
        o_apb.pready  = 1'b1;
        o_apb.pslverr = 1'b0;
        case (i_apb.paddr)
            REG_CTRL:    o_apb.prdata = {31'd0, enable};   // Clear reads back as 0
            REG_BLOCKS:  o_apb.prdata = blk_cnt;
            REG_DATA:    o_apb.prdata = data_cnt;
            REG_CTRLW:   o_apb.prdata = ctrl_cnt;
            REG_INVALID: o_apb.prdata = inv_cnt;
            default:     o_apb.pslverr = apb_access;
        endcase
        // Counters are read only
        if (apb_access && i_apb.pwrite && i_apb.paddr != REG_CTRL) o_apb.pslverr = 1'b1;
    end

    // Head word waits unchanged until it is popped
    a_head_stable: assert property (@(posedge clk) disable iff (i_rst)
        i_word_valid && !o_pop |=> i_word_valid && $stable(i_word));

endmodule

`default_nettype wire

//--- logic/baser_transcoder_257b.sv
`timescale 1ns/1ps
`default_nettype none

module baser_transcoder_257b import baser_pkg::*; (
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_valid,
    input  baser_quad_t i_quad,
    output logic        o_ready,
    output logic        o_valid,
    output tc_word_t    o_word,
    input  logic        i_ready
);

    logic [3:0]      is_data;     // Per-block data flags
    logic            any_bad;
    logic            seen_ctrl;
    logic [TC_W-1:0] next_word;

    // Sync header decode
    always_comb begin
        is_data = '0;
        any_bad = 1'b0;
        for (int i = 0; i < 4; i++) begin
            is_data[i] = (i_quad[i].sync == SYNC_DATA);
            if (i_quad[i].sync != SYNC_DATA && i_quad[i].sync != SYNC_CTRL) begin
                any_bad = 1'b1;
            end
        end
    end

    // Packing, block 0 lowest
    always_comb begin
        next_word = '0;
        seen_ctrl = 1'b0;
        if (&is_data) begin
            next_word[0] = 1'b1;
            for (int i = 0; i < 4; i++) begin
                next_word[1 + BLK_PAYLOAD_W*i +: BLK_PAYLOAD_W] = i_quad[i].payload;
            end
        end else begin
            next_word[4:1] = is_data;
            for (int i = 0; i < 3; i++) begin
                if (seen_ctrl) begin
                    next_word[1 + BLK_PAYLOAD_W*i +: BLK_PAYLOAD_W] = i_quad[i].payload;
                end else if (is_data[i]) begin
                    next_word[5 + BLK_PAYLOAD_W*i +: BLK_PAYLOAD_W] = i_quad[i].payload;
                end else begin
                    // First control block loses its type nibble
                    next_word[5 + BLK_PAYLOAD_W*i +: CTRL_KEEP_W] =
                        i_quad[i].payload[BLK_PAYLOAD_W-1:TYPE_W];
                    seen_ctrl = 1'b1;
                end
            end
            // No control block yet, so block 3 must be the first one
            if (seen_ctrl) begin
                next_word[1 + BLK_PAYLOAD_W*3 +: BLK_PAYLOAD_W] = i_quad[3].payload;
            end else begin
                next_word[5 + BLK_PAYLOAD_W*3 +: CTRL_KEEP_W] =
                    i_quad[3].payload[BLK_PAYLOAD_W-1:TYPE_W];
            end
        end
    end

    assign o_ready = !o_valid || i_ready;   // Stage empty or draining

    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid && o_ready) begin
            o_word.word     <= next_word;
            o_word.bad_sync <= any_bad;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (i_rst)
        o_valid && !i_ready |=> o_valid && $stable(o_word));

endmodule

`default_nettype wire

//--- logic/baser_word_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module baser_word_fifo #(
    parameter type T_PAYLOAD = logic [7:0],
    parameter int  DEPTH     = 4            // Power of two
) (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_push,
    input  T_PAYLOAD i_data,
    input  logic     i_pop,
    output logic     o_full,
    output logic     o_empty,
    output T_PAYLOAD o_data
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    T_PAYLOAD mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;   // Occupancy

    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_empty = (count == '0);
    assign o_data  = mem[rd_ptr];   // Head word, valid when not empty

    // Pointers wrap naturally with a power-of-two depth
    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (i_rst)
        i_push |-> !o_full || i_pop);

    a_no_underflow: assert property (@(posedge clk) disable iff (i_rst)
        i_pop |-> !o_empty);

endmodule

`default_nettype wire

//--- logic/baser_pkg.sv
`default_nettype none

package baser_pkg;

    localparam int BLK_PAYLOAD_W = 64;
    localparam int TYPE_W        = 4;                        // Type nibble of a control block
    localparam int CTRL_KEEP_W   = BLK_PAYLOAD_W - TYPE_W;   // Bits kept of the first control block
    localparam int TC_W          = 4 * BLK_PAYLOAD_W + 1;
    localparam int APB_ADDR_W    = 5;

    localparam logic [7:0] DATA_PATTERN = 8'hAA;
    localparam logic [7:0] CTRL_PATTERN = 8'h55;

    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;

    localparam logic [APB_ADDR_W-1:0] REG_CTRL    = 5'h00;
    localparam logic [APB_ADDR_W-1:0] REG_BLOCKS  = 5'h04;
    localparam logic [APB_ADDR_W-1:0] REG_DATA    = 5'h08;
    localparam logic [APB_ADDR_W-1:0] REG_CTRLW   = 5'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_INVALID = 5'h10;

    typedef struct packed {
        logic [1:0]               sync;
        logic [BLK_PAYLOAD_W-1:0] payload;
    } baser_block_t;

    // Index 0 is the block that arrived first
    typedef baser_block_t [3:0] baser_quad_t;

    typedef struct packed {
        logic [TC_W-1:0] word;
        logic            bad_sync;
    } tc_word_t;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [31:0]           pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire
